/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP = pipeTb
FILELIST = src.f
OBJDIR = obj_dir
PASSMSG = NO ERRORS

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASSMSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* hdl/fetchPc.sv */
`timescale 1ns/1ps

module fetchPc (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic redirect,
	input logic [31:0] redirectPc,
	output logic [31:0] imemAddr,
	input logic [31:0] imemData,
	stageBus.up slot
);
	logic [31:0] pc;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= pipePkg::resetPc;
		end else if (redirect) begin
			pc <= redirectPc; // Wins over a held front end.
		end else if (wr) begin
			pc <= pc + 32'd4;
		end
	end

	assign imemAddr = pc;

	// Memory answers in the same cycle.
	assign slot.pc = pc;
	assign slot.instr = imemData;
	assign slot.valid = !redirect; // Wrong-path word.
	assign slot.exception = 1'b0;
	assign slot.excCode = pipePkg::excNone;

endmodule

/* hdl/mulDivTimer.sv */
`timescale 1ns/1ps

module mulDivTimer (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy
);
	logic [2:0] count;

	always_ff @(posedge clk) begin
		if (!rst) begin
			count <= 3'd0;
		end else if (start) begin
			count <= 3'(pipePkg::mulDivCycles);
		end else if (count != 3'd0) begin
			count <= count - 3'd1;
		end
	end

	assign busy = (count != 3'd0);

endmodule

/* hdl/pipeCtrl.sv */
`timescale 1ns/1ps

module pipeCtrl (
	input logic clk,
	input logic rst,
	input logic dataStall,
	input logic irq,
	stageBus.down busE,
	stageBus.down busM,
	stageBus.down busW,
	input logic mdBusy,
	output logic mdStart,
	output logic wrF,
	output logic wrD,
	output logic wrE,
	output logic wrM,
	output logic wrW,
	output logic flushD,
	output logic flushE,
	output logic flushM,
	output logic flushW,
	output logic redirect,
	output logic [31:0] redirectPc,
	output logic commitValid,
	output logic [31:0] commitPc,
	output logic [31:0] commitInstr,
	output logic excTaken,
	output pipePkg::excCodeT excCode,
	output logic [31:0] epc
);
	pipePkg::ctrlStateT state;
	pipePkg::ctrlStateT stateNext;
	pipePkg::opcodeT opE;
	pipePkg::opcodeT opM;
	logic go;
	logic isInt;
	logic takeEret;
	logic frontHold;
	logic [31:0] retPc;

	function automatic pipePkg::opcodeT classify(input logic [31:0] instr);
		logic [5:0] op;
		logic [5:0] fn;
		op = instr[31:26];
		fn = instr[5:0];
		if (instr == 32'h0000_0000) begin
			return pipePkg::opNop;
		end
		if (instr == pipePkg::eretWord) begin
			return pipePkg::opEret;
		end
		if (op == pipePkg::opSpecial && fn == pipePkg::fnSyscall) begin
			return pipePkg::opSyscall;
		end
		if (op == pipePkg::opSpecial && (fn == pipePkg::fnMult || fn == pipePkg::fnMultu ||
				fn == pipePkg::fnDiv || fn == pipePkg::fnDivu)) begin
			return pipePkg::opMulDiv;
		end
		return pipePkg::opAlu;
	endfunction

	assign opE = classify(busE.instr);
	assign opM = classify(busM.instr);
	assign go = !dataStall; // The whole pipe freezes on a data stall.

	// ################################################
	// Exception and return decision in memory.
	// ################################################
	// Interrupts wait until the first slot of a redirected path has passed.
	assign isInt = irq && (state != pipePkg::stRedirect);
	assign excTaken = go && busM.valid &&
		(busM.exception || opM == pipePkg::opSyscall || isInt);
	assign takeEret = go && busM.valid && !excTaken && (opM == pipePkg::opEret);
	assign redirect = excTaken || takeEret;
	assign redirectPc = excTaken ? pipePkg::excVector : retPc;

	always_comb begin
		if (isInt) begin
			excCode = pipePkg::excInt;
		end else if (busM.exception) begin
			excCode = busM.excCode;
		end else begin
			excCode = pipePkg::excSys;
		end
	end

	assign epc = busM.pc;

	always_ff @(posedge clk) begin
		if (excTaken) begin
			retPc <= (opM == pipePkg::opSyscall && !isInt) ? busM.pc + 32'd4 : busM.pc;
		end
	end

	// ################################################
	// Stage writes and flushes.
	// ################################################
	assign mdStart = go && !redirect && busE.valid && (opE == pipePkg::opMulDiv) &&
		(state != pipePkg::stMulDiv);
	assign frontHold = mdStart || (state == pipePkg::stMulDiv && mdBusy);

	assign wrF = go && !frontHold;
	assign wrD = go && !frontHold;
	assign wrE = go && !frontHold;
	assign wrM = go;
	assign wrW = go;
	assign flushD = redirect;
	assign flushE = redirect;
	assign flushM = redirect || (go && frontHold); // Bubbles behind a held execute.
	assign flushW = excTaken; // An ERET still retires.

	assign commitValid = go && busW.valid && !busW.exception;
	assign commitPc = busW.pc;
	assign commitInstr = busW.instr;

	// ################################################
	// Control FSM.
	// ################################################
	always_comb begin
		stateNext = state;
		case (state)
			pipePkg::stRun: begin
				if (mdStart) begin
					stateNext = pipePkg::stMulDiv;
				end
			end
			pipePkg::stMulDiv: begin
				if (go && !mdBusy) begin
					stateNext = pipePkg::stRun; // Mult/div leaves execute now.
				end
			end
			default: begin
				if (mdStart) begin
					stateNext = pipePkg::stMulDiv;
				end else if (go && busM.valid) begin
					stateNext = pipePkg::stRun;
				end
			end
		endcase
		if (redirect) begin
			stateNext = pipePkg::stRedirect;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= pipePkg::stRun;
		end else begin
			state <= stateNext;
		end
	end

endmodule

/* hdl/pipePkg.sv */
package pipePkg;

	// ################################################
	// Fetch addresses and multicycle timing.
	// ################################################
	localparam logic [31:0] resetPc = 32'hbfc0_0000;
	localparam logic [31:0] excVector = 32'hbfc0_0380;
	localparam int mulDivCycles = 4; // Cycles a mult/div holds execute.

	// ################################################
	// Instruction encodings.
	// ################################################
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnDiv = 6'h1a;
	localparam logic [5:0] fnDivu = 6'h1b;
	localparam logic [5:0] fnSyscall = 6'h0c;
	localparam logic [31:0] eretWord = 32'h4200_0018;

	typedef enum logic [2:0] {
		opAlu,
		opMulDiv,
		opSyscall,
		opEret,
		opNop
	} opcodeT;

	// excNone shares code 0 with excInt, excTaken tells them apart.
	typedef enum logic [4:0] {
		excInt = 5'd0,
		excSys = 5'd8
	} excCodeT;
	localparam excCodeT excNone = excInt;

	typedef enum logic [1:0] {
		stRun,
		stMulDiv,
		stRedirect // Redirected fetch, waiting for the new path in memory.
	} ctrlStateT;

endpackage

/* hdl/pipeTop.sv */
`timescale 1ns/1ps

module pipeTop (
	input logic clk,
	input logic rst,
	output logic [31:0] imemAddr,
	input logic [31:0] imemData,
	input logic dataStall,
	input logic irq,
	output logic commitValid,
	output logic [31:0] commitPc,
	output logic [31:0] commitInstr,
	output logic excTaken,
	output pipePkg::excCodeT excCode,
	output logic [31:0] epc
);
	logic wrF;
	logic wrD;
	logic wrE;
	logic wrM;
	logic wrW;
	logic flushD;
	logic flushE;
	logic flushM;
	logic flushW;
	logic redirect;
	logic [31:0] redirectPc;
	logic mdStart;
	logic mdBusy;

	stageBus busF();
	stageBus busD();
	stageBus busE();
	stageBus busM();
	stageBus busW();

	fetchPc i_fetchPc (
		.clk(clk),
		.rst(rst),
		.wr(wrF),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.slot(busF)
	);

	stageReg i_stageD (.clk(clk), .rst(rst), .wr(wrD), .flush(flushD), .prev(busF), .next(busD));
	stageReg i_stageE (.clk(clk), .rst(rst), .wr(wrE), .flush(flushE), .prev(busD), .next(busE));
	stageReg i_stageM (.clk(clk), .rst(rst), .wr(wrM), .flush(flushM), .prev(busE), .next(busM));
	stageReg i_stageW (.clk(clk), .rst(rst), .wr(wrW), .flush(flushW), .prev(busM), .next(busW));

	mulDivTimer i_mulDivTimer (
		.clk(clk),
		.rst(rst),
		.start(mdStart),
		.busy(mdBusy)
	);

	pipeCtrl i_pipeCtrl (
		.clk(clk),
		.rst(rst),
		.dataStall(dataStall),
		.irq(irq),
		.busE(busE),
		.busM(busM),
		.busW(busW),
		.mdBusy(mdBusy),
		.mdStart(mdStart),
		.wrF(wrF),
		.wrD(wrD),
		.wrE(wrE),
		.wrM(wrM),
		.wrW(wrW),
		.flushD(flushD),
		.flushE(flushE),
		.flushM(flushM),
		.flushW(flushW),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.commitValid(commitValid),
		.commitPc(commitPc),
		.commitInstr(commitInstr),
		.excTaken(excTaken),
		.excCode(excCode),
		.epc(epc)
	);

endmodule

/* hdl/stageBus.sv */
`timescale 1ns/1ps

interface stageBus;
	logic [31:0] pc;
	logic [31:0] instr;
	logic valid;
	logic exception; // Fault raised by an earlier stage.
	pipePkg::excCodeT excCode;

	modport up (
		output pc,
		output instr,
		output valid,
		output exception,
		output excCode
	);

	modport down (
		input pc,
		input instr,
		input valid,
		input exception,
		input excCode
	);
endinterface

/* hdl/stageReg.sv */
`timescale 1ns/1ps

module stageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	stageBus.down prev,
	stageBus.up next
);

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			next.valid <= 1'b0;
			next.exception <= 1'b0;
			next.excCode <= pipePkg::excNone;
			next.instr <= 32'h0000_0000; // Pc is left alone.
		end else if (wr) begin
			next.pc <= prev.pc;
			next.instr <= prev.instr;
			next.valid <= prev.valid;
			next.exception <= prev.exception;
			next.excCode <= prev.excCode;
		end
	end

endmodule

/* src.f */
hdl/pipePkg.sv
hdl/stageBus.sv
hdl/stageReg.sv
hdl/fetchPc.sv
hdl/mulDivTimer.sv
hdl/pipeCtrl.sv
hdl/pipeTop.sv
test/pipeCtrl_asserts.sv
test/pipeTb.sv

/* test/pipeCtrl_asserts.sv */
`timescale 1ns/1ps

module pipeCtrl_asserts (
	input logic clk,
	input logic rst,
	input pipePkg::ctrlStateT state,
	input logic mdBusy,
	input logic excTaken,
	input logic commitValid,
	input logic redirect,
	input logic flushD,
	input logic flushE
);

	// Excepting slot is dropped before writeback.
	excNoCommit: assert property (@(posedge clk) disable iff (!rst)
		excTaken |=> !commitValid)
		else $error("Slot that took an exception was committed.");

	redirectFlush: assert property (@(posedge clk) disable iff (!rst)
		redirect |-> (flushD && flushE))
		else $error("Redirect without flushing decode and execute.");

	// Busy timer pins the FSM in stMulDiv.
	mulDivHold: assert property (@(posedge clk) disable iff (!rst)
		(state == pipePkg::stMulDiv && mdBusy) |=> state == pipePkg::stMulDiv)
		else $error("FSM left stMulDiv while the multiply/divide was busy.");

endmodule

bind pipeCtrl pipeCtrl_asserts i_pipeCtrlAsserts (
	.clk(clk),
	.rst(rst),
	.state(state),
	.mdBusy(mdBusy),
	.excTaken(excTaken),
	.commitValid(commitValid),
	.redirect(redirect),
	.flushD(flushD),
	.flushE(flushE)
);

/* test/pipeTb.sv */
`timescale 1ns/1ps

module pipeTb;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 2;
	localparam int firstCommitCycle = 4; // Fetched in cycle 0, in writeback after four edges.
	localparam int watchdogSlack = 50;
	localparam vectorFile = "test/pipeVectors.txt";
	localparam logic [31:0] nopWord = 32'h0000_0000;

	typedef struct packed {
		logic isExc;
		logic [31:0] a; // Commit pc, or exception code.
		logic [31:0] b; // Commit word, or epc.
	} recordT;

	logic clk = 1'b0;
	logic rst;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic dataStall;
	logic irq;
	logic commitValid;
	logic [31:0] commitPc;
	logic [31:0] commitInstr;
	logic excTaken;
	pipePkg::excCodeT excCode;
	logic [31:0] epc;

	logic [31:0] romWords [256]; // One 1 KB page at resetPc.
	logic stallSeq [$];
	logic irqSeq [$];
	recordT expQ [$];
	int posEdges = 0;
	int lastCommit = -1;
	logic loadDone = 1'b0;

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk) begin
		posEdges <= posEdges + 1;
	end

	// Same-cycle instruction memory, NOP outside the listed words.
	assign imemData = (imemAddr[31:10] == pipePkg::resetPc[31:10]) ? romWords[imemAddr[9:2]] :
		nopWord;

	pipeTop i_pipeTop (
		.clk(clk),
		.rst(rst),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dataStall(dataStall),
		.irq(irq),
		.commitValid(commitValid),
		.commitPc(commitPc),
		.commitInstr(commitInstr),
		.excTaken(excTaken),
		.excCode(excCode),
		.epc(epc)
	);

	// ################################################
	// Reporting and checks.
	// ################################################
	task automatic stopRun();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	function automatic logic isMulDiv(input logic [31:0] word);
		return word[31:26] == pipePkg::opSpecial && word[5:2] == 4'b0110; // Functions 18 to 1b.
	endfunction

	task automatic loadVectors();
		int fd;
		int n;
		int count;
		int stall;
		int irqLevel;
		string line;
		string tag;
		logic [31:0] a;
		logic [31:0] b;
		recordT rec;
		foreach (romWords[i]) begin
			romWords[i] = nopWord;
		end
		fd = $fopen(vectorFile, "r");
		if (fd == 0) begin
			$display("Cannot open the vector file %s.", vectorFile);
			stopRun();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0) begin
				n = $sscanf(line, "%s", tag);
			end
			if (n > 0 && tag.getc(0) != "#") begin
				if (tag == "S") begin
					n = $sscanf(line, "%s %d %d %d", tag, count, stall, irqLevel);
					repeat (count) begin
						stallSeq.push_back(stall != 0);
						irqSeq.push_back(irqLevel != 0);
					end
				end else begin
					n = $sscanf(line, "%s %h %h", tag, a, b);
					rec.isExc = (tag == "X");
					rec.a = a;
					rec.b = b;
					if (tag == "P" && a[31:10] == pipePkg::resetPc[31:10]) begin
						romWords[a[9:2]] = b;
					end else if (tag == "C" || tag == "X") begin
						expQ.push_back(rec);
					end else begin
						$display("Vector line not understood: %s", line);
						stopRun();
					end
				end
			end
		end
		$fclose(fd);
		loadDone = 1'b1;
	endtask

	task automatic matchCommit();
		recordT rec;
		int now;
		now = posEdges - resetCycles;
		if (expQ.size() == 0) begin
			$display("Commit of pc %h arrived after the expected trace ended.", commitPc);
			stopRun();
		end else begin
			rec = expQ.pop_front();
			if (rec.isExc) begin
				$display("Commit of pc %h arrived where an exception was expected.", commitPc);
				stopRun();
			end else begin
				checkValue("commitPc", commitPc, rec.a);
				checkValue("commitInstr", commitInstr, rec.b);
				if (lastCommit < 0) begin
					checkValue("first commit cycle", now, firstCommitCycle);
				end else if (isMulDiv(commitInstr)) begin
					checkValue("mult/div commit gap ok",
						32'(now - lastCommit >= pipePkg::mulDivCycles), 32'd1);
				end
				lastCommit = now;
			end
		end
	endtask

	task automatic matchException();
		recordT rec;
		if (expQ.size() == 0) begin
			$display("Exception at pc %h arrived after the expected trace ended.", epc);
			stopRun();
		end else begin
			rec = expQ.pop_front();
			if (!rec.isExc) begin
				$display("Exception at pc %h arrived where commit of %h was expected.", epc, rec.a);
				stopRun();
			end else begin
				checkValue("excCode", 32'(excCode), rec.a);
				checkValue("epc", epc, rec.b);
			end
		end
	endtask

	// Outputs settle mid-cycle, well after the input update.
	always @(negedge clk) begin
		if (posEdges > 0 && posEdges <= resetCycles) begin
			checkValue("imemAddr", imemAddr, pipePkg::resetPc);
			checkValue("commitValid", 32'(commitValid), 32'd0);
			checkValue("excTaken", 32'(excTaken), 32'd0);
		end else if (posEdges > resetCycles) begin
			if (dataStall) begin
				checkValue("commitValid", 32'(commitValid), 32'd0);
			end
			if (commitValid) begin
				matchCommit(); // Older slot first.
			end
			if (excTaken) begin
				matchException();
			end
		end
	end

	// ################################################
	// Stimulus and watchdog.
	// ################################################
	initial begin
		rst = 1'b0;
		dataStall = 1'b0;
		irq = 1'b0;
		loadVectors();
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b1;
		for (int c = 0; c < stallSeq.size(); c++) begin
			dataStall = stallSeq[c];
			irq = irqSeq[c];
			@(posedge clk);
			#1;
		end
		if (expQ.size() != 0) begin
			$display("Run ended with %0d expected records that never appeared.", expQ.size());
			stopRun();
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

	initial begin
		wait (loadDone);
		#((stallSeq.size() + watchdogSlack) * clkPeriod);
		$display("Watchdog expired, the run hung or commits never arrived.");
		stopRun();
	end

endmodule

/* test/pipeVectors.txt */
# P addr word: program word at a byte address. S cycles stall irq: input levels for n cycles.
# C pc instr: expected commit. X code epc: expected exception. Hex except on S lines.
P bfc00000 3c081234
P bfc00004 25080010
P bfc00008 00850018
P bfc0000c 00a61823
P bfc00010 0000000c
P bfc00014 24060007
P bfc00018 00c73024
P bfc0001c 34e70010
P bfc00020 01095025
P bfc00024 8d0a0000
P bfc00028 016c6821
P bfc0002c ac0b0004
P bfc00030 25290004
P bfc00380 42000018
S 22 0 0
S 1 0 1
S 10 0 0
S 3 1 0
S 4 0 0
C bfc00000 3c081234
C bfc00004 25080010
C bfc00008 00850018
C bfc0000c 00a61823
X 08 bfc00010
C bfc00380 42000018
C bfc00014 24060007
C bfc00018 00c73024
X 00 bfc0001c
C bfc00380 42000018
C bfc0001c 34e70010
C bfc00020 01095025
C bfc00024 8d0a0000
C bfc00028 016c6821
C bfc0002c ac0b0004
C bfc00030 25290004
